// File: design/tex_types_pkg.sv
`default_nettype none

package tex_types_pkg;

    // Texel layouts selected through CTRL bits 2:0.
    typedef enum logic [2:0] {
        R8G8B8A8 = 3'd0,
        R5G6B5   = 3'd1,
        R4G4B4A4 = 3'd2,
        L8A8     = 3'd3,
        A8       = 3'd4,
        L8       = 3'd5
    } tex_format_e;

    typedef enum logic {
        POINT    = 1'b0,
        BILINEAR = 1'b1
    } tex_filter_e;

    localparam int TEX_NUM_TEXELS = 4;
    localparam int TEX_FRAC_BITS  = 8;

    // Footprint order is top-left, top-right, bottom-left, bottom-right.
    typedef struct packed {
        logic [TEX_FRAC_BITS-1:0]        v_frac;
        logic [TEX_FRAC_BITS-1:0]        u_frac;
        logic [TEX_NUM_TEXELS-1:0][31:0] texels;
    } tex_req_t;

    // One colour sample split into 8-bit lanes, ch0 in the low byte.
    typedef struct packed {
        logic [7:0] ch3;
        logic [7:0] ch2;
        logic [7:0] ch1;
        logic [7:0] ch0;
    } tex_chan_t;

endpackage

`default_nettype wire

// File: design/tex_apb_pkg.sv
`default_nettype none

package tex_apb_pkg;

    typedef struct packed {
        logic [7:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Register map.
    typedef enum logic [7:0] {
        REG_CTRL   = 8'h00,
        REG_STATUS = 8'h04
    } tex_reg_e;

endpackage

`default_nettype wire

// File: design/tex_csr.sv
`timescale 1ns/1ps
`default_nettype none

module tex_csr
    import tex_types_pkg::*, tex_apb_pkg::*;
#(
    parameter int CNT_WIDTH = 16
) (
    input  logic        clk,
    input  logic        arst_n,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    input  logic        done,
    output tex_format_e format,
    output tex_filter_e filter
);

    tex_format_e          format_q;
    tex_filter_e          filter_q;
    logic [CNT_WIDTH-1:0] cnt_q;
    logic                 access;
    logic                 ctrl_wr;
    logic [31:0]          ctrl_rdata;

    assign access  = apb_req.psel & apb_req.penable;
    assign ctrl_wr = access & apb_req.pwrite & (apb_req.paddr == REG_CTRL);

    // Unused CTRL bits read back as zero.
    assign ctrl_rdata = {27'b0, filter_q, 1'b0, format_q};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            format_q <= R8G8B8A8;
            filter_q <= POINT;
        end else if (ctrl_wr) begin
            format_q <= tex_format_e'(apb_req.pwdata[2:0]);
            filter_q <= tex_filter_e'(apb_req.pwdata[4]);
        end
    end

    // Completed samples, wrapping at CNT_WIDTH bits.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
        end else if (done) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Zero-wait slave, so the response is decoded straight from the request.
    always_comb begin
        apb_rsp.pready  = apb_req.psel;
        apb_rsp.prdata  = '0;
        apb_rsp.pslverr = 1'b0;
        case (apb_req.paddr)
            REG_CTRL: begin
                apb_rsp.prdata = ctrl_rdata;
            end
            REG_STATUS: begin
                apb_rsp.prdata  = 32'(cnt_q);
                apb_rsp.pslverr = access & apb_req.pwrite;
            end
            default: begin
                apb_rsp.pslverr = access;
            end
        endcase
    end

    assign format = format_q;
    assign filter = filter_q;

endmodule

`default_nettype wire

// File: design/tex_format.sv
`timescale 1ns/1ps
`default_nettype none

module tex_format
    import tex_types_pkg::*;
(
    input  logic [TEX_NUM_TEXELS-1:0][31:0] texels,
    input  tex_format_e                     format,
    output tex_chan_t [TEX_NUM_TEXELS-1:0]  lerp_texels,
    output logic [3:0]                      color_enable,
    output logic [31:0]                     pt_color
);

    // Narrow fields are zero-extended into their 8-bit lane.
    function automatic tex_chan_t unpack(input logic [31:0] texel, input tex_format_e fmt);
        tex_chan_t c;
        c = '0;
        case (fmt)
            R5G6B5: begin
                c.ch0 = 8'(texel[4:0]);
                c.ch1 = 8'(texel[10:5]);
                c.ch2 = 8'(texel[15:11]);
            end
            R4G4B4A4: begin
                c.ch0 = 8'(texel[3:0]);
                c.ch1 = 8'(texel[7:4]);
                c.ch2 = 8'(texel[11:8]);
                c.ch3 = 8'(texel[15:12]);
            end
            L8A8: begin
                c.ch0 = texel[7:0];
                c.ch1 = texel[15:8];
            end
            A8, L8: begin
                c.ch0 = texel[7:0];
            end
            // Codes 6 and 7 fall back to R8G8B8A8.
            default: begin
                c.ch0 = texel[7:0];
                c.ch1 = texel[15:8];
                c.ch2 = texel[23:16];
                c.ch3 = texel[31:24];
            end
        endcase
        return c;
    endfunction

    always_comb begin
        for (int i = 0; i < TEX_NUM_TEXELS; i++) begin
            lerp_texels[i] = unpack(texels[i], format);
        end
    end

    always_comb begin
        case (format)
            R5G6B5:   color_enable = 4'b0111;
            L8A8:     color_enable = 4'b0011;
            A8, L8:   color_enable = 4'b0001;
            default:  color_enable = 4'b1111;
        endcase
    end

    // Point colour is texel 0; R5G6B5 puts opaque alpha in byte 0
    // and shifts its three fields up one byte.
    always_comb begin
        if (format == R5G6B5) begin
            pt_color = {lerp_texels[0].ch2, lerp_texels[0].ch1, lerp_texels[0].ch0, 8'hFF};
        end else begin
            pt_color = lerp_texels[0];
        end
    end

endmodule

`default_nettype wire

// File: design/tex_lerp.sv
`timescale 1ns/1ps
`default_nettype none

module tex_lerp
    import tex_types_pkg::*;
(
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  tex_chan_t [TEX_NUM_TEXELS-1:0]  lerp_texels,
    input  logic [3:0]                      color_enable,
    input  logic [31:0]                     pt_color,
    input  logic [TEX_FRAC_BITS-1:0]        u_frac,
    input  logic [TEX_FRAC_BITS-1:0]        v_frac,
    input  tex_filter_e                     filter,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [31:0]                     out_color
);

    localparam int WGT_W = TEX_FRAC_BITS + 1;
    localparam int SUM_W = 8 + TEX_FRAC_BITS + 1;

    // Everything stage 2 needs travels with the item.
    typedef struct packed {
        tex_chan_t                top;
        tex_chan_t                bot;
        logic [TEX_FRAC_BITS-1:0] v_frac;
        logic [3:0]               color_enable;
        logic [31:0]              pt_color;
        tex_filter_e              filter;
    } stage1_t;

    function automatic logic [7:0] lerp8(input logic [7:0] a, input logic [7:0] b,
                                         input logic [TEX_FRAC_BITS-1:0] f);
        logic [WGT_W-1:0] wa;
        logic [SUM_W-1:0] sum;
        wa  = WGT_W'(1 << TEX_FRAC_BITS) - WGT_W'(f);
        sum = SUM_W'(a) * SUM_W'(wa) + SUM_W'(b) * SUM_W'(f);
        return sum[TEX_FRAC_BITS +: 8];
    endfunction

    function automatic tex_chan_t lerp_chan(input tex_chan_t a, input tex_chan_t b,
                                            input logic [TEX_FRAC_BITS-1:0] f);
        tex_chan_t r;
        r.ch0 = lerp8(a.ch0, b.ch0, f);
        r.ch1 = lerp8(a.ch1, b.ch1, f);
        r.ch2 = lerp8(a.ch2, b.ch2, f);
        r.ch3 = lerp8(a.ch3, b.ch3, f);
        return r;
    endfunction

    stage1_t     s1_d;
    stage1_t     s1_q;
    logic        s1_valid_q;
    logic        s1_ready;
    logic        s2_valid_q;
    logic        s2_ready;
    logic [31:0] s2_color_d;
    logic [31:0] s2_color_q;
    tex_chan_t   vert;
    tex_chan_t   bil;

    // A stage loads when empty or when its successor is moving.
    assign s2_ready = ~s2_valid_q | out_ready;
    assign s1_ready = ~s1_valid_q | s2_ready;
    assign in_ready = s1_ready;

    // Horizontal blends along the top and bottom rows.
    always_comb begin
        s1_d.top          = lerp_chan(lerp_texels[0], lerp_texels[1], u_frac);
        s1_d.bot          = lerp_chan(lerp_texels[2], lerp_texels[3], u_frac);
        s1_d.v_frac       = v_frac;
        s1_d.color_enable = color_enable;
        s1_d.pt_color     = pt_color;
        s1_d.filter       = filter;
    end

    // Vertical blend, then disabled channels forced to 0xFF.
    always_comb begin
        vert    = lerp_chan(s1_q.top, s1_q.bot, s1_q.v_frac);
        bil.ch0 = s1_q.color_enable[0] ? vert.ch0 : 8'hFF;
        bil.ch1 = s1_q.color_enable[1] ? vert.ch1 : 8'hFF;
        bil.ch2 = s1_q.color_enable[2] ? vert.ch2 : 8'hFF;
        bil.ch3 = s1_q.color_enable[3] ? vert.ch3 : 8'hFF;
        s2_color_d = (s1_q.filter == BILINEAR) ? bil : s1_q.pt_color;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_ready) s1_valid_q <= in_valid;
            if (s2_ready) s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && s1_ready) s1_q <= s1_d;
        if (s1_valid_q && s2_ready) s2_color_q <= s2_color_d;
    end

    assign out_valid = s2_valid_q;
    assign out_color = s2_color_q;

endmodule

`default_nettype wire

// File: design/tex_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module tex_sampler
    import tex_types_pkg::*, tex_apb_pkg::*;
#(
    parameter int CNT_WIDTH = 16
) (
    input  logic        clk,
    input  logic        arst_n,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    input  logic        req_valid,
    output logic        req_ready,
    input  tex_req_t    req,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output logic [31:0] rsp_color
);

    tex_format_e                    format;
    tex_filter_e                    filter;
    tex_chan_t [TEX_NUM_TEXELS-1:0] lerp_texels;
    logic [3:0]                     color_enable;
    logic [31:0]                    pt_color;

    // One completed sample per output transfer.
    wire done = rsp_valid & rsp_ready;

    tex_csr #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_csr (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .done    (done),
        .format  (format),
        .filter  (filter)
    );

    tex_format u_format (
        .texels       (req.texels),
        .format       (format),
        .lerp_texels  (lerp_texels),
        .color_enable (color_enable),
        .pt_color     (pt_color)
    );

    tex_lerp u_lerp (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (req_valid),
        .in_ready     (req_ready),
        .lerp_texels  (lerp_texels),
        .color_enable (color_enable),
        .pt_color     (pt_color),
        .u_frac       (req.u_frac),
        .v_frac       (req.v_frac),
        .filter       (filter),
        .out_valid    (rsp_valid),
        .out_ready    (rsp_ready),
        .out_color    (rsp_color)
    );

endmodule

`default_nettype wire

// File: testbench/tex_sampler_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tex_sampler_assertions
    import tex_apb_pkg::*;
(
    input logic        clk,
    input logic        arst_n,
    input apb_req_t    apb_req,
    input apb_rsp_t    apb_rsp,
    input logic        rsp_valid,
    input logic        rsp_ready,
    input logic [31:0] rsp_color
);

    // A stalled response keeps its valid and its colour.
    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_color))
        else $error("rsp_valid or rsp_color changed under back-pressure");

    // Zero-wait slave.
    a_pready: assert property (@(posedge clk) disable iff (!arst_n)
        apb_req.psel |-> apb_rsp.pready)
        else $error("pready low during an APB transfer");

    a_color_known: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> !$isunknown(rsp_color))
        else $error("rsp_color has unknown bits while rsp_valid is high");

    a_reset_idle: assert property (@(posedge clk) $rose(arst_n) |-> !rsp_valid)
        else $error("rsp_valid high right after reset");

endmodule

bind tex_sampler tex_sampler_assertions u_assertions (
    .clk       (clk),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_color (rsp_color)
);

`default_nettype wire

// File: testbench/tex_sampler_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tex_sampler_tb
    import tex_types_pkg::*, tex_apb_pkg::*;
;
    localparam int NUM_REQS = 64;

    logic        clk;
    logic        arst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        req_valid;
    logic        req_ready;
    tex_req_t    req;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_color;

    logic [31:0] seed = 32'd29745;
    logic [2:0]  cur_fmt;
    logic        cur_filt;
    tex_req_t    pend_q[$];
    logic [31:0] exp_q[$];
    int          accept_q[$];
    int          cycle_no;
    int          completed;
    logic [31:0] last_color;

    tex_sampler #(.CNT_WIDTH(16)) u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_color (rsp_color)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (NUM_REQS * 20 + 2000) @(posedge clk);
        fail_now("Timeout: the DUT stopped making progress");
    end

    task fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[31:16], seed[15:0] ^ seed[31:16]};
    endfunction

    function automatic tex_req_t random_request();
        tex_req_t    r;
        logic [31:0] fr;
        for (int i = 0; i < TEX_NUM_TEXELS; i++) r.texels[i] = next_random();
        fr = next_random();
        r.u_frac = fr[7:0];
        r.v_frac = fr[23:16];
        return r;
    endfunction

    // Channel lanes per format, narrow fields zero-extended.
    function automatic logic [31:0] chan_ref(input logic [31:0] t, input logic [2:0] fmt);
        case (fmt)
            R5G6B5:   return {8'h00, 3'b0, t[15:11], 2'b0, t[10:5], 3'b0, t[4:0]};
            R4G4B4A4: return {4'h0, t[15:12], 4'h0, t[11:8], 4'h0, t[7:4], 4'h0, t[3:0]};
            L8A8:     return {16'h0000, t[15:0]};
            A8, L8:   return {24'h000000, t[7:0]};
            default:  return t;
        endcase
    endfunction

    function automatic logic [3:0] enable_ref(input logic [2:0] fmt);
        case (fmt)
            R5G6B5:  return 4'b0111;
            L8A8:    return 4'b0011;
            A8, L8:  return 4'b0001;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] blend_ref(input tex_req_t r, input logic [2:0] fmt);
        logic [31:0] c[4];
        logic [31:0] res;
        logic [3:0]  en;
        int          top;
        int          bot;
        int          mix;
        en = enable_ref(fmt);
        for (int i = 0; i < 4; i++) c[i] = chan_ref(r.texels[i], fmt);
        for (int k = 0; k < 4; k++) begin
            top = (int'(c[0][8*k +: 8]) * (256 - int'(r.u_frac))
                   + int'(c[1][8*k +: 8]) * int'(r.u_frac)) / 256;
            bot = (int'(c[2][8*k +: 8]) * (256 - int'(r.u_frac))
                   + int'(c[3][8*k +: 8]) * int'(r.u_frac)) / 256;
            mix = (top * (256 - int'(r.v_frac)) + bot * int'(r.v_frac)) / 256;
            res[8*k +: 8] = en[k] ? mix[7:0] : 8'hFF;
        end
        return res;
    endfunction

    function automatic logic [31:0] expected_color(input tex_req_t r);
        logic [31:0] c;
        c = chan_ref(r.texels[0], cur_fmt);
        if (cur_filt) return blend_ref(r, cur_fmt);
        if (cur_fmt == R5G6B5) return {c[23:0], 8'hFF};
        return c;
    endfunction

    task apb_access(input logic [7:0] addr, input logic write, input logic [31:0] wdata,
                    output logic [31:0] rdata, output logic err);
        apb_req.paddr   = addr;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        check("pready", 32'(apb_rsp.pready), 32'd1);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b1, data, rdata, err);
        check("pslverr", 32'(err), 32'(exp_err));
        if (addr == REG_CTRL) begin
            cur_fmt  = data[2:0];
            cur_filt = data[4];
        end
    endtask

    task apb_read(input logic [7:0] addr, input logic [31:0] exp_data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b0, 32'h0, rdata, err);
        check("pslverr", 32'(err), 32'(exp_err));
        if (!exp_err) check("prdata", rdata, exp_data);
    endtask

    // One clock of both streams; handshakes are sampled at the falling edge.
    task stream_cycle(output int latency);
        logic take;
        latency = -1;
        @(negedge clk);
        take = req_valid && req_ready;
        if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) fail_now("Response arrived with no request in flight");
            check("rsp_color", rsp_color, exp_q.pop_front());
            latency    = cycle_no - accept_q.pop_front();
            last_color = rsp_color;
            completed++;
        end
        if (take) begin
            exp_q.push_back(expected_color(req));
            accept_q.push_back(cycle_no);
        end
        cycle_no++;
        @(posedge clk);
        #1;
        if (take) begin
            if (pend_q.size() > 0) req = pend_q.pop_front();
            else req_valid = 1'b0;
        end
    endtask

    task start_stream();
        req       = pend_q.pop_front();
        req_valid = 1'b1;
    endtask

    task drain(input logic check_latency);
        int lat;
        rsp_ready = 1'b1;
        while (req_valid || exp_q.size() > 0) begin
            stream_cycle(lat);
            if (check_latency && lat >= 0) check("latency", 32'(lat), 32'd2);
        end
    endtask

    task register_access();
        apb_read(REG_CTRL, 32'h0, 1'b0);
        apb_read(REG_STATUS, 32'h0, 1'b0);
        apb_write(REG_CTRL, 32'hFFFF_FFFF, 1'b0);
        apb_read(REG_CTRL, 32'h17, 1'b0);
        apb_write(8'h08, 32'h1234_5678, 1'b1);
        apb_read(8'h08, 32'h0, 1'b1);
        apb_write(REG_STATUS, 32'h0000_00A5, 1'b1);
        apb_read(REG_STATUS, 32'h0, 1'b0);
        apb_write(REG_CTRL, 32'h0, 1'b0);
    endtask

    task point_mode();
        for (int f = 0; f < 6; f++) begin
            apb_write(REG_CTRL, 32'(f), 1'b0);
            repeat (4) pend_q.push_back(random_request());
            start_stream();
            drain(1'b0);
        end
    endtask

    task bilinear_mode();
        tex_req_t    r;
        logic [31:0] exp;
        logic [3:0]  en;
        for (int f = 0; f < 6; f++) begin
            apb_write(REG_CTRL, 32'h10 | 32'(f), 1'b0);
            r = random_request();
            r.u_frac = '0;
            r.v_frac = '0;
            pend_q.push_back(r);
            start_stream();
            drain(1'b0);
            // Zero weights give texel 0 itself.
            exp = chan_ref(r.texels[0], 3'(f));
            en  = enable_ref(3'(f));
            for (int k = 0; k < 4; k++) if (!en[k]) exp[8*k +: 8] = 8'hFF;
            check("rsp_color", last_color, exp);
            repeat (3) pend_q.push_back(random_request());
            start_stream();
            drain(1'b0);
        end
    endtask

    task back_pressure();
        logic [31:0] held;
        int          lat;
        apb_write(REG_CTRL, 32'h10, 1'b0);
        rsp_ready = 1'b0;
        repeat (4) pend_q.push_back(random_request());
        start_stream();
        repeat (6) stream_cycle(lat);
        check("items_in_flight", 32'(exp_q.size()), 32'd2);
        check("req_ready", 32'(req_ready), 32'd0);
        check("rsp_valid", 32'(rsp_valid), 32'd1);
        held = rsp_color;
        // Items in flight keep the filter they were accepted with.
        apb_write(REG_CTRL, 32'h01, 1'b0);
        check("rsp_color", rsp_color, held);
        drain(1'b0);
    endtask

    task latency_and_count();
        apb_write(REG_CTRL, 32'h0, 1'b0);
        repeat (12) pend_q.push_back(random_request());
        start_stream();
        drain(1'b1);
        apb_read(REG_STATUS, 32'(completed), 1'b0);
    endtask

    initial begin
        arst_n     = 1'b0;
        apb_req    = '0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b0;
        cur_fmt    = 3'd0;
        cur_filt   = 1'b0;
        cycle_no   = 0;
        completed  = 0;
        last_color = '0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check("rsp_valid", 32'(rsp_valid), 32'd0);
        check("req_ready", 32'(req_ready), 32'd1);
        check("pslverr", 32'(apb_rsp.pslverr), 32'd0);
        register_access();
        point_mode();
        bilinear_mode();
        back_pressure();
        latency_and_count();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: tex_sampler.f
design/tex_types_pkg.sv
design/tex_apb_pkg.sv
design/tex_csr.sv
design/tex_format.sv
design/tex_lerp.sv
design/tex_sampler.sv
testbench/tex_sampler_assertions.sv
testbench/tex_sampler_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tex_sampler.f \
    --top-module tex_sampler_tb -o tex_sampler_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tex_sampler_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" <<< "$output"; then
    exit 0
fi
echo "Simulation did not report success"
exit 1
